/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [63:0] xlen_t;     // register / data value
    typedef logic [63:0] pc_t;       // instruction address
    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // register number

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;

    // field lsb positions
    localparam int rd_pos     = 7;
    localparam int funct3_pos = 12;
    localparam int rs1_pos    = 15;
    localparam int rs2_pos    = 20;
    localparam int funct7_pos = 25;

    // alu funct3
    localparam logic [2:0] f3_add  = 3'b000;  // add/sub/addi/addw
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // srl and sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_mul  = 3'b000;  // mul/mulw under f7_mext

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra
    localparam logic [6:0] f7_mext = 7'b0000001;  // M extension

endpackage

/* logic/ex_ctrl_pkg.sv */
package ex_ctrl_pkg;

    // alu operation picked by the EX decode
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_addw,   // word forms sign-extend bit 31
        alu_subw,
        alu_link,   // pc+4 for jalr
        alu_none
    } alu_op_e;

    // iterative multiplier
    typedef enum logic [1:0] {
        mul_idle,
        mul_busy,
        mul_done
    } mul_state_e;

endpackage

/* logic/id_ex_reg.sv */
module id_ex_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                branch_flush,
    input  logic                load_en,
    input  logic                valid_id_ex,
    input  rv_isa_pkg::pc_t     pc_id_ex,
    input  rv_isa_pkg::inst_t   inst_id_ex,
    input  rv_isa_pkg::xlen_t   imm_id_ex,
    input  rv_isa_pkg::xlen_t   src_a_id_ex,
    input  rv_isa_pkg::xlen_t   src_b_id_ex,
    output logic                ex_valid,
    output rv_isa_pkg::pc_t     ex_pc,
    output rv_isa_pkg::inst_t   ex_inst,
    output rv_isa_pkg::xlen_t   ex_imm,
    output rv_isa_pkg::xlen_t   ex_src_a,
    output rv_isa_pkg::xlen_t   ex_src_b
);

    // valid bit: flush beats stall
    always_ff @(posedge clk) begin
        if (rst || branch_flush) begin
            ex_valid <= 1'b0;
        end else if (load_en) begin
            ex_valid <= valid_id_ex;
        end
    end

    // payload only moves with load_en
    always_ff @(posedge clk) begin
        if (load_en) begin
            ex_pc    <= pc_id_ex;
            ex_inst  <= inst_id_ex;
            ex_imm   <= imm_id_ex;
            ex_src_a <= src_a_id_ex;  // regfile rs1
            ex_src_b <= src_b_id_ex;  // regfile rs2
        end
    end

endmodule

/* logic/operand_forward.sv */
module operand_forward (
    input  logic                ex_valid,
    input  rv_isa_pkg::inst_t   ex_inst,
    input  rv_isa_pkg::xlen_t   ex_src_a,
    input  rv_isa_pkg::xlen_t   ex_src_b,
    input  logic                mem_valid,
    input  rv_isa_pkg::inst_t   mem_inst,
    input  rv_isa_pkg::xlen_t   mem_alu_result,
    input  logic                wb_valid,
    input  rv_isa_pkg::inst_t   wb_inst,
    input  rv_isa_pkg::xlen_t   wb_wdata,
    output rv_isa_pkg::xlen_t   src1,
    output rv_isa_pkg::xlen_t   src2
);
    import rv_isa_pkg::*;

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   mem_rd;
    reg_idx_t   wb_rd;
    logic [6:0] ex_opc;
    logic [6:0] mem_opc;
    logic [6:0] wb_opc;
    logic       mem_writer;
    logic       wb_writer;
    logic       uses_rs2;

    assign rs1     = ex_inst[rs1_pos +: 5];
    assign rs2     = ex_inst[rs2_pos +: 5];
    assign mem_rd  = mem_inst[rd_pos +: 5];
    assign wb_rd   = wb_inst[rd_pos +: 5];
    assign ex_opc  = ex_inst[6:0];
    assign mem_opc = mem_inst[6:0];
    assign wb_opc  = wb_inst[6:0];

    // mem stage only has alu results ready
    assign mem_writer = mem_valid &&
                        (mem_opc inside {opc_op, opc_op_imm, opc_op_32, opc_op_imm_32});
    // wb also carries load data, links and upper immediates
    assign wb_writer  = wb_valid &&
                        (wb_opc inside {opc_op, opc_op_imm, opc_op_32, opc_op_imm_32,
                                        opc_load, opc_jal, opc_lui, opc_auipc});
    assign uses_rs2   = ex_opc inside {opc_op, opc_op_32, opc_store, opc_branch};

    // priority mem > wb > regfile, x0 never forwarded
    always_comb begin
        if (!ex_valid)
            src1 = '0;
        else if (mem_writer && mem_rd == rs1 && rs1 != '0)
            src1 = mem_alu_result;
        else if (wb_writer && wb_rd == rs1 && rs1 != '0)
            src1 = wb_wdata;
        else
            src1 = ex_src_a;
    end

    always_comb begin
        if (!ex_valid)
            src2 = '0;
        else if (uses_rs2 && mem_writer && mem_rd == rs2 && rs2 != '0)
            src2 = mem_alu_result;
        else if (uses_rs2 && wb_writer && wb_rd == rs2 && rs2 != '0)
            src2 = wb_wdata;
        else
            src2 = ex_src_b;
    end

endmodule

/* logic/int_alu.sv */
module int_alu (
    input  logic                ex_valid,
    input  rv_isa_pkg::pc_t     ex_pc,
    input  rv_isa_pkg::inst_t   ex_inst,
    input  rv_isa_pkg::xlen_t   ex_imm,
    input  rv_isa_pkg::xlen_t   src1,
    input  rv_isa_pkg::xlen_t   src2,
    input  rv_isa_pkg::xlen_t   mul_product,
    output rv_isa_pkg::xlen_t   alu_result
);
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    logic [6:0] opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_mul;
    logic       imm_shift;
    alu_op_e    op;
    xlen_t      opa;
    xlen_t      opb;
    xlen_t      sum;
    xlen_t      diff;
    xlen_t      res;

    assign opc       = ex_inst[6:0];
    assign funct3    = ex_inst[funct3_pos +: 3];
    assign funct7    = ex_inst[funct7_pos +: 7];
    assign is_mul    = (opc == opc_op || opc == opc_op_32) &&
                       funct7 == f7_mext && funct3 == f3_mul;
    assign imm_shift = opc == opc_op_imm && (funct3 == f3_sll || funct3 == f3_srl);

    always_comb begin
        op = alu_none;
        case (opc)
            opc_op, opc_op_imm: begin
                case (funct3)
                    f3_add:  op = (opc == opc_op && funct7 == f7_alt) ? alu_sub : alu_add;
                    f3_sll:  op = alu_sll;
                    f3_slt:  op = alu_slt;
                    f3_sltu: op = alu_sltu;
                    f3_xor:  op = alu_xor;
                    f3_srl:  op = ex_inst[30] ? alu_sra : alu_srl;  // bit 30 in funct6 too
                    f3_or:   op = alu_or;
                    default: op = alu_and;
                endcase
            end
            opc_op_32: begin
                if (funct3 == f3_add)  // addw/subw, other word ops dropped
                    op = (funct7 == f7_alt) ? alu_subw : alu_addw;
            end
            opc_op_imm_32: op = alu_addw;                      // addiw
            opc_load, opc_store, opc_branch: op = alu_add;    // address / target
            opc_jalr: op = alu_link;
            default: op = alu_none;
        endcase
    end

    // branch target is pc based
    assign opa = (opc == opc_branch) ? ex_pc : src1;

    always_comb begin
        if (imm_shift)
            opb = {58'd0, ex_inst[25:20]};  // 6 bit shamt
        else if (opc inside {opc_op_imm, opc_op_imm_32, opc_load, opc_store, opc_branch})
            opb = ex_imm;
        else
            opb = src2;
    end

    assign sum  = opa + opb;
    assign diff = opa - opb;

    always_comb begin
        case (op)
            alu_add:  res = sum;
            alu_sub:  res = diff;
            alu_sll:  res = opa << opb[5:0];
            alu_slt:  res = {63'd0, $signed(opa) < $signed(opb)};
            alu_sltu: res = {63'd0, opa < opb};
            alu_xor:  res = opa ^ opb;
            alu_srl:  res = opa >> opb[5:0];
            alu_sra:  res = $signed(opa) >>> opb[5:0];
            alu_or:   res = opa | opb;
            alu_and:  res = opa & opb;
            alu_addw: res = {{32{sum[31]}}, sum[31:0]};
            alu_subw: res = {{32{diff[31]}}, diff[31:0]};
            alu_link: res = ex_pc + 64'd4;  // return address
            default:  res = '0;
        endcase
    end

    // product already word-extended by the multiplier
    assign alu_result = !ex_valid ? '0 : (is_mul ? mul_product : res);

endmodule

/* logic/branch_unit.sv */
module branch_unit (
    input  logic                ex_valid,
    input  rv_isa_pkg::pc_t     ex_pc,
    input  rv_isa_pkg::inst_t   ex_inst,
    input  rv_isa_pkg::xlen_t   src1,
    input  rv_isa_pkg::xlen_t   src2,
    input  rv_isa_pkg::pc_t     target,
    input  logic                ready_ex_mem,
    output rv_isa_pkg::pc_t     dnpc,
    output logic                pc_update
);
    import rv_isa_pkg::*;

    logic is_branch;
    logic is_jalr;
    logic taken;
    logic predicted;

    assign is_branch = ex_inst[6:0] == opc_branch;
    assign is_jalr   = ex_inst[6:0] == opc_jalr;
    assign predicted = ex_inst[31];  // imm sign, backward => taken

    always_comb begin
        case (ex_inst[funct3_pos +: 3])
            f3_beq:  taken = src1 == src2;
            f3_bne:  taken = src1 != src2;
            f3_blt:  taken = $signed(src1) < $signed(src2);
            f3_bge:  taken = $signed(src1) >= $signed(src2);
            f3_bltu: taken = src1 < src2;
            f3_bgeu: taken = src1 >= src2;
            default: taken = 1'b0;  // reserved encodings
        endcase
    end

    // redirect only on mispredict, jalr always
    assign pc_update = ex_valid && ready_ex_mem &&
                       (is_jalr || (is_branch && taken != predicted));

    // predicted-taken miss falls back to pc+4
    assign dnpc = (is_jalr || (is_branch && taken && !predicted)) ? target : ex_pc + 64'd4;

endmodule

/* logic/seq_multiplier.sv */
module seq_multiplier #(
    parameter int mul_step_bits = 2  // 1, 2 or 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                start,
    input  logic                word,
    input  rv_isa_pkg::xlen_t   multiplicand,
    input  rv_isa_pkg::xlen_t   multiplier,
    output logic                busy,
    output logic                done,
    output rv_isa_pkg::xlen_t   product
);
    import rv_isa_pkg::*;
    import ex_ctrl_pkg::*;

    localparam int steps = 64 / mul_step_bits;

    mul_state_e state;
    logic [6:0] cnt;     // steps left minus one
    logic       word_q;
    xlen_t      mcand;
    xlen_t      mplier;
    xlen_t      acc;
    xlen_t      acc_next;

    // add shifted multiplicand for each set bit of this slice
    always_comb begin
        acc_next = acc;
        for (int i = 0; i < mul_step_bits; i++) begin
            if (mplier[i])
                acc_next = acc_next + (mcand << i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= mul_idle;
        end else begin
            case (state)
                mul_idle: if (start) state <= mul_busy;
                mul_busy: if (cnt == '0) state <= mul_done;
                mul_done: if (start) state <= mul_idle;  // start here = consumer took it
                default:  state <= mul_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mul_idle && start) begin
            mcand  <= multiplicand;
            mplier <= multiplier;
            acc    <= '0;
            cnt    <= 7'(steps - 1);
            word_q <= word;
        end else if (state == mul_busy) begin
            acc    <= acc_next;
            mcand  <= mcand << mul_step_bits;
            mplier <= mplier >> mul_step_bits;
            cnt    <= cnt - 7'd1;
        end
    end

    assign busy    = state == mul_busy;
    assign done    = state == mul_done;
    // low 64 bits are the same signed or unsigned
    assign product = word_q ? {{32{acc[31]}}, acc[31:0]} : acc;

endmodule

/* logic/ex_stage.sv */
module ex_stage #(
    parameter int mul_step_bits = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_id_ex,
    output logic                ready_id_ex,
    input  rv_isa_pkg::pc_t     pc_id_ex,
    input  rv_isa_pkg::inst_t   inst_id_ex,
    input  rv_isa_pkg::xlen_t   imm_id_ex,
    input  rv_isa_pkg::xlen_t   src_a_id_ex,
    input  rv_isa_pkg::xlen_t   src_b_id_ex,
    input  logic                mem_valid,
    input  rv_isa_pkg::inst_t   mem_inst,
    input  rv_isa_pkg::xlen_t   mem_alu_result,
    input  logic                wb_valid,
    input  rv_isa_pkg::inst_t   wb_inst,
    input  rv_isa_pkg::xlen_t   wb_wdata,
    input  logic                branch_flush,
    input  logic                ready_ex_mem,
    output logic                valid_ex_mem,
    output rv_isa_pkg::pc_t     pc_ex_mem,
    output rv_isa_pkg::inst_t   inst_ex_mem,
    output rv_isa_pkg::xlen_t   alu_result,
    output rv_isa_pkg::xlen_t   store_data,
    output rv_isa_pkg::pc_t     dnpc,
    output logic                pc_update
);
    import rv_isa_pkg::*;

    logic  ex_valid;
    pc_t   ex_pc;
    inst_t ex_inst;
    xlen_t ex_imm;
    xlen_t ex_src_a;
    xlen_t ex_src_b;
    xlen_t src1;
    xlen_t src2;
    xlen_t jalr_sum;
    pc_t   target;
    xlen_t mul_product;
    logic  ex_mul;
    logic  mul_busy;
    logic  mul_done;
    logic  ex_block;

    id_ex_reg id_ex_reg_inst (
        .clk(clk), .rst(rst), .branch_flush(branch_flush), .load_en(ready_id_ex),
        .valid_id_ex(valid_id_ex), .pc_id_ex(pc_id_ex), .inst_id_ex(inst_id_ex),
        .imm_id_ex(imm_id_ex), .src_a_id_ex(src_a_id_ex), .src_b_id_ex(src_b_id_ex),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .ex_imm(ex_imm),
        .ex_src_a(ex_src_a), .ex_src_b(ex_src_b)
    );

    operand_forward operand_forward_inst (
        .ex_valid(ex_valid), .ex_inst(ex_inst), .ex_src_a(ex_src_a), .ex_src_b(ex_src_b),
        .mem_valid(mem_valid), .mem_inst(mem_inst), .mem_alu_result(mem_alu_result),
        .wb_valid(wb_valid), .wb_inst(wb_inst), .wb_wdata(wb_wdata),
        .src1(src1), .src2(src2)
    );

    int_alu int_alu_inst (
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .ex_imm(ex_imm),
        .src1(src1), .src2(src2), .mul_product(mul_product), .alu_result(alu_result)
    );

    // jalr target needs rs1+imm, alu_result holds the link value
    assign jalr_sum = src1 + ex_imm;
    assign target   = (ex_inst[6:0] == opc_jalr) ? {jalr_sum[63:1], 1'b0} : alu_result;

    branch_unit branch_unit_inst (
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .src1(src1), .src2(src2),
        .target(target), .ready_ex_mem(ready_ex_mem), .dnpc(dnpc), .pc_update(pc_update)
    );

    // valid mul or mulw sitting in EX
    assign ex_mul = ex_valid && (ex_inst[6:0] == opc_op || ex_inst[6:0] == opc_op_32) &&
                    ex_inst[funct7_pos +: 7] == f7_mext && ex_inst[funct3_pos +: 3] == f3_mul;

    seq_multiplier #(
        .mul_step_bits(mul_step_bits)
    ) seq_multiplier_inst (
        .clk(clk), .rst(rst), .flush(branch_flush),
        .start(ex_mul && ready_ex_mem),  // also the release in done
        .word(ex_inst[6:0] == opc_op_32),
        .multiplicand(src1), .multiplier(src2),
        .busy(mul_busy), .done(mul_done), .product(mul_product)
    );

    // held until the product shows
    assign ex_block     = mul_busy || (ex_mul && !mul_done);
    assign ready_id_ex  = ready_ex_mem && !ex_block;
    assign valid_ex_mem = ex_valid && !ex_block;
    assign pc_ex_mem    = ex_pc;
    assign inst_ex_mem  = ex_inst;
    assign store_data   = src2;  // forwarded rs2

endmodule

/* bench/ex_model.svh */
// reference model of the EX stage, evaluated on the recorded slot s_*

// class test for older instructions, late = writeback view
function automatic logic writes_rd(input logic v, input logic [31:0] ins, input logic late);
    logic [6:0] o;
    logic       alu_class;
    logic       late_class;
    o          = ins[6:0];
    alu_class  = o == opc_op || o == opc_op_imm || o == opc_op_32 || o == opc_op_imm_32;
    late_class = o == opc_load || o == opc_jal || o == opc_lui || o == opc_auipc;
    return v && (alu_class || (late && late_class));
endfunction

// mem beats wb beats regfile, x0 stays local
function automatic logic [63:0] operand(input logic [4:0] rs, input logic [63:0] rf);
    if (rs != 5'd0 && writes_rd(s_mv, s_mi, 1'b0) && s_mi[11:7] == rs)
        return s_mr;
    if (rs != 5'd0 && writes_rd(s_wv, s_wi, 1'b1) && s_wi[11:7] == rs)
        return s_wd;
    return rf;
endfunction

function automatic logic [63:0] model_rs1();
    return operand(s_inst[19:15], s_a);
endfunction

function automatic logic [63:0] model_rs2();
    logic [6:0] o;
    o = s_inst[6:0];
    if (o == opc_op || o == opc_op_32 || o == opc_store || o == opc_branch)
        return operand(s_inst[24:20], s_b);
    return s_b;  // no rs2 read, regfile value passes
endfunction

function automatic logic model_is_mul();
    return (s_inst[6:0] == opc_op || s_inst[6:0] == opc_op_32) &&
           s_inst[31:25] == 7'b0000001 && s_inst[14:12] == 3'd0;
endfunction

function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
endfunction

// plain RV64 register/immediate op
function automatic logic [63:0] rv_op(input logic [2:0] f3, input logic alt,
                                      input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    sa = a;
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[5:0];
        3'd2: return {63'd0, $signed(a) < $signed(b)};
        3'd3: return {63'd0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt)
                return sa >>> b[5:0];  // arithmetic
            return a >> b[5:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic [63:0] model_result();
    logic [63:0] a;
    logic [63:0] b;
    logic [2:0]  f3;
    logic        sh;
    a  = model_rs1();
    b  = model_rs2();
    f3 = s_inst[14:12];
    sh = f3 == 3'd1 || f3 == 3'd5;
    case (s_inst[6:0])
        opc_op:        return s_inst[25] ? a * b : rv_op(f3, s_inst[30], a, b);
        opc_op_imm:    return rv_op(f3, f3 == 3'd5 && s_inst[30], a,
                                    sh ? {58'd0, s_inst[25:20]} : s_imm);
        opc_op_32:     return sext32(s_inst[25] ? a * b : (s_inst[30] ? a - b : a + b));
        opc_op_imm_32: return sext32(a + s_imm);
        opc_load, opc_store: return a + s_imm;   // effective address
        opc_branch:    return s_pc + s_imm;      // target
        opc_jalr:      return s_pc + 64'd4;      // link
        default:       return 64'd0;
    endcase
endfunction

function automatic logic model_taken();
    logic [63:0] a;
    logic [63:0] b;
    a = model_rs1();
    b = model_rs2();
    case (s_inst[14:12])
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// backward (bit 31 set) predicted taken
function automatic logic model_redirect();
    if (s_inst[6:0] == opc_jalr)
        return 1'b1;
    if (s_inst[6:0] == opc_branch)
        return model_taken() != s_inst[31];
    return 1'b0;
endfunction

function automatic logic [63:0] model_dnpc();
    logic [63:0] t;
    t = model_rs1() + s_imm;
    if (s_inst[6:0] == opc_jalr)
        return {t[63:1], 1'b0};
    if (s_inst[6:0] == opc_branch && model_taken() && !s_inst[31])
        return s_pc + s_imm;
    return s_pc + 64'd4;
endfunction

/* bench/ex_stage_tb.sv */
module ex_stage_tb;
    import rv_isa_pkg::*;

    localparam int mul_step_bits = 2;
    localparam int n_inst        = 2000;
    localparam int mul_worst     = 64 + 2;                  // 1 bit per cycle plus start/done
    localparam int cycle_limit   = n_inst * (mul_worst + 20);

    logic  clk;
    logic  rst;
    logic  valid_id_ex;
    logic  ready_id_ex;
    pc_t   pc_id_ex;
    inst_t inst_id_ex;
    xlen_t imm_id_ex;
    xlen_t src_a_id_ex;
    xlen_t src_b_id_ex;
    logic  mem_valid;
    inst_t mem_inst;
    xlen_t mem_alu_result;
    logic  wb_valid;
    inst_t wb_inst;
    xlen_t wb_wdata;
    logic  branch_flush;
    logic  ready_ex_mem;
    logic  valid_ex_mem;
    pc_t   pc_ex_mem;
    inst_t inst_ex_mem;
    xlen_t alu_result;
    xlen_t store_data;
    pc_t   dnpc;
    logic  pc_update;

    // model slot, the instruction expected in EX
    logic  s_valid;
    pc_t   s_pc;
    inst_t s_inst;
    xlen_t s_imm;
    xlen_t s_a;
    xlen_t s_b;
    logic  s_mv;   // forwarding inputs seen at acceptance
    inst_t s_mi;
    xlen_t s_mr;
    logic  s_wv;
    inst_t s_wi;
    xlen_t s_wd;

    int n_acc;
    int cycles;
    logic [31:0] lfsr = 32'h9b71;

    `include "ex_model.svh"

    ex_stage #(.mul_step_bits(mul_step_bits)) ex_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rnd(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [6:0] any_opcode(input logic [3:0] n);
        case (n)
            4'd0:    return opc_op;
            4'd1:    return opc_op_32;
            4'd2:    return opc_op_imm_32;
            4'd3:    return opc_load;
            4'd4:    return opc_store;     // never a writer
            4'd5:    return opc_branch;
            4'd6:    return opc_jal;
            4'd7:    return opc_jalr;
            4'd8:    return opc_lui;
            4'd9:    return opc_auipc;
            default: return opc_op_imm;
        endcase
    endfunction

    // new mem/wb view, only on an acceptance edge
    task automatic new_forwarding();
        logic [31:0] mi;
        logic [31:0] wi;
        mi      = 32'(rnd(32));
        wi      = 32'(rnd(32));
        mi[6:0] = any_opcode(4'(rnd(4)));
        wi[6:0] = any_opcode(4'(rnd(4)));
        if (rnd(1) != '0)
            mi[11:7] = (rnd(1) != '0) ? s_inst[19:15] : s_inst[24:20];  // aim rd at a source
        if (rnd(1) != '0)
            wi[11:7] = (rnd(1) != '0) ? s_inst[19:15] : s_inst[24:20];
        s_mv = rnd(2) != '0;
        s_wv = rnd(2) != '0;
        s_mi = mi;
        s_wi = wi;
        s_mr = rnd(64);
        s_wd = rnd(64);
        mem_valid      <= s_mv;
        mem_inst       <= s_mi;
        mem_alu_result <= s_mr;
        wb_valid       <= s_wv;
        wb_inst        <= s_wi;
        wb_wdata       <= s_wd;
    endtask

    task automatic offer_new();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [11:0] i12;
        logic [31:0] ins;
        logic [63:0] imm;
        logic [63:0] a;
        logic [63:0] pcv;
        kind = 4'(rnd(4));
        f3   = 3'(rnd(3));
        i12  = 12'(rnd(12));
        ins  = 32'(rnd(32));
        f7   = 7'd0;
        imm  = {{52{i12[11]}}, i12};
        case (kind)
            4'd0, 4'd1: begin
                opc = opc_op;
                if (f3 == f3_add || f3 == f3_srl)
                    f7 = (rnd(1) != '0) ? f7_alt : 7'd0;  // sub / sra
            end
            4'd4: begin
                opc = opc_op_32;
                f3  = f3_add;
                f7  = (rnd(1) != '0) ? f7_alt : 7'd0;
            end
            4'd5: begin
                opc = opc_op_imm_32;
                f3  = f3_add;
            end
            4'd6: begin
                opc = opc_load;
                f3  = 3'd3;
            end
            4'd7: begin
                opc = opc_store;
                f3  = 3'd3;
            end
            4'd8, 4'd9: begin
                opc = opc_branch;
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 ^ 3'b110;  // no branch on 2/3, fold to blt/bge
                imm = {{51{i12[11]}}, i12, 1'b0};
            end
            4'd10: begin
                opc = opc_jalr;
                f3  = 3'd0;
            end
            4'd11: begin
                opc = opc_op;
                f3  = f3_mul;
                f7  = f7_mext;
            end
            4'd12: begin
                opc = opc_op_32;
                f3  = f3_mul;
                f7  = f7_mext;
            end
            default: opc = opc_op_imm;
        endcase
        ins[6:0]   = opc;
        ins[14:12] = f3;
        if (opc == opc_op || opc == opc_op_32) begin
            ins[31:25] = f7;
        end else if (opc == opc_op_imm && (f3 == f3_sll || f3 == f3_srl)) begin
            ins[31:26] = {1'b0, f3 == f3_srl && rnd(1) != '0, 4'd0};  // slli/srli/srai
            imm        = {{52{ins[31]}}, ins[31:20]};
        end else if (opc == opc_store || opc == opc_branch) begin
            ins[31] = i12[11];  // sign only, rs2 field kept
        end else begin
            ins[31:20] = i12;
        end
        a        = rnd(64);
        pcv      = rnd(64);
        pcv[1:0] = 2'b00;
        valid_id_ex <= 1'b1;
        pc_id_ex    <= pcv;
        inst_id_ex  <= ins;
        imm_id_ex   <= imm;
        src_a_id_ex <= a;
        src_b_id_ex <= (rnd(2) == '0) ? a : rnd(64);  // equal operands now and then
    endtask

    // called right at the edge, DUT values are still the pre-edge ones
    task automatic step_edge();
        logic accept;
        logic took;
        if (!s_valid && valid_ex_mem)
            fail_run("valid_ex_mem high with no live instruction in EX");
        if (s_valid && !valid_ex_mem && !model_is_mul())
            fail_run("accepted instruction missing from the EX outputs");
        compare_value("ready_id_ex", 64'(ready_id_ex),
                      64'(ready_ex_mem && (!s_valid || valid_ex_mem)));
        compare_value("pc_update", 64'(pc_update),
                      64'(valid_ex_mem && ready_ex_mem && model_redirect()));
        if (valid_ex_mem) begin  // also covers the hold under back-pressure
            compare_value("pc_ex_mem", pc_ex_mem, s_pc);
            compare_value("inst_ex_mem", 64'(inst_ex_mem), 64'(s_inst));
            compare_value("alu_result", alu_result, model_result());
            if (s_inst[6:0] == opc_store)
                compare_value("store_data", store_data, model_rs2());
            if (s_inst[6:0] == opc_branch || s_inst[6:0] == opc_jalr)
                compare_value("dnpc", dnpc, model_dnpc());
        end
        if (valid_ex_mem && ready_ex_mem)
            s_valid = 1'b0;
        accept = valid_id_ex && ready_id_ex && !branch_flush;
        took   = valid_id_ex && (ready_id_ex || branch_flush);
        if (branch_flush || ready_id_ex)
            s_valid = 1'b0;  // flushed, or a bubble loads
        if (accept) begin
            s_valid = 1'b1;
            s_pc    = pc_id_ex;
            s_inst  = inst_id_ex;
            s_imm   = imm_id_ex;
            s_a     = src_a_id_ex;
            s_b     = src_b_id_ex;
            n_acc++;
            new_forwarding();
        end
        branch_flush <= rnd(6) == '0;   // rare
        ready_ex_mem <= rnd(2) != '0;   // low a quarter of the time
        if (took || !valid_id_ex) begin
            if (n_acc < n_inst && rnd(2) != '0)
                offer_new();
            else
                valid_id_ex <= 1'b0;
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit)
                fail_run("timeout, the stage stopped retiring instructions");
        end
    end

    initial begin
        rst            = 1'b1;
        valid_id_ex    = 1'b0;
        pc_id_ex       = '0;
        inst_id_ex     = '0;
        imm_id_ex      = '0;
        src_a_id_ex    = '0;
        src_b_id_ex    = '0;
        mem_valid      = 1'b0;
        mem_inst       = '0;
        mem_alu_result = '0;
        wb_valid       = 1'b0;
        wb_inst        = '0;
        wb_wdata       = '0;
        branch_flush   = 1'b0;
        ready_ex_mem   = 1'b0;
        s_valid        = 1'b0;
        n_acc          = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (n_acc < n_inst || s_valid) begin
            @(posedge clk);
            step_edge();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+bench
logic/rv_isa_pkg.sv
logic/ex_ctrl_pkg.sv
logic/id_ex_reg.sv
logic/operand_forward.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/seq_multiplier.sv
logic/ex_stage.sv
bench/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# build the EX stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
    verilator --binary --timing -f list.f --top-module ex_stage_tb -o ex_stage_tb_sim &&
    ./obj_dir/ex_stage_tb_sim ||
    { echo "simulation build or run failed"; exit 1; }
